//--- design/scope_text_pkg.sv
`default_nettype none

package scope_text_pkg;

   // ----------------------------------------
   // data widths
   // ----------------------------------------
   typedef logic [11:0] reading_t;     // raw acquisition code
   typedef logic [13:0] millivolt_t;   // scaled value, up to 12285
   typedef logic [23:0] bcd6_t;        // six digits, msd first
   typedef logic [10:0] coord_t;       // hcount / vcount
   typedef logic [11:0] rgb_t;         // 4 bits per channel
   typedef logic [4:0]  glyph_code_t;
   typedef logic [63:0] glyph_bits_t;  // line 0 in top byte, left pixel in msb

   typedef enum logic [2:0] {
      ROW_NONE,
      ROW_MAX,
      ROW_MIN,
      ROW_MEAN,
      ROW_TRIG
   } row_sel_t;

   // ----------------------------------------
   // screen layout
   // ----------------------------------------
   localparam int TEXT_X0    = 768;
   localparam int TEXT_CHARS = 15;
   localparam int CHAR_W     = 8;
   localparam int ROW_H      = 16;   // 8-line glyphs shown twice as tall

   localparam int ROW_Y_MAX  = 16;
   localparam int ROW_Y_MIN  = 32;
   localparam int ROW_Y_MEAN = 48;
   localparam int ROW_Y_TRIG = 144;

   localparam int   MV_PER_LSB = 3;
   localparam rgb_t TEXT_FG    = 12'hFF0;

   // glyph codes, digits 0..9 map to themselves
   localparam glyph_code_t GLYPH_SPACE = 5'd10;
   localparam glyph_code_t GLYPH_EQ    = 5'd11;
   localparam glyph_code_t GLYPH_UC_V  = 5'd12;
   localparam glyph_code_t GLYPH_M     = 5'd13;
   localparam glyph_code_t GLYPH_A     = 5'd14;
   localparam glyph_code_t GLYPH_X     = 5'd15;
   localparam glyph_code_t GLYPH_I     = 5'd16;
   localparam glyph_code_t GLYPH_N     = 5'd17;
   localparam glyph_code_t GLYPH_E     = 5'd18;
   localparam glyph_code_t GLYPH_UC_T  = 5'd19;
   localparam glyph_code_t GLYPH_L     = 5'd20;
   localparam glyph_code_t GLYPH_LC_V  = 5'd21;

endpackage

`default_nettype wire

//--- design/reading_to_bcd.sv
`default_nettype none

module reading_to_bcd
   import scope_text_pkg::*;
#(
   parameter int MV_PER_LSB = scope_text_pkg::MV_PER_LSB
) (
   input  wire           clk,
   input  wire           rst,
   input  wire reading_t reading,
   output bcd6_t         bcd
);

   millivolt_t mv;        // scaled reading, stage 1
   bcd6_t      bcd_nxt;

   // shift-and-add-3 over all bits of the scaled value
   function automatic bcd6_t bin_to_bcd(input millivolt_t bin);
      bcd6_t acc;
      acc = '0;
      for (int i = $bits(millivolt_t) - 1; i >= 0; i--) begin
         for (int d = 0; d < 6; d++) begin
            if (acc[4*d +: 4] > 4'd4) begin
               acc[4*d +: 4] = acc[4*d +: 4] + 4'd3;
            end
         end
         acc = {acc[22:0], bin[i]};
      end
      return acc;
   endfunction

   function automatic logic digits_valid(input bcd6_t v);
      logic ok;
      ok = 1'b1;
      for (int d = 0; d < 6; d++) begin
         if (v[4*d +: 4] > 4'd9) begin
            ok = 1'b0;
         end
      end
      return ok;
   endfunction

   // ----------------------------------------
   // scale, then convert
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         mv <= '0;
      end else begin
         mv <= millivolt_t'(reading * MV_PER_LSB);   // 4095 * 3 fits in 14 bits
      end
   end

   assign bcd_nxt = bin_to_bcd(mv);

   always_ff @(posedge clk) begin
      if (rst) begin
         bcd <= '0;
      end else begin
         bcd <= bcd_nxt;
      end
   end

   // every digit shown must be a decimal one
   a_bcd_digits : assert property (@(posedge clk) disable iff (rst)
      !$past(rst) |-> digits_valid(bcd))
      else $error("bcd digit out of range: %h", bcd);

endmodule

`default_nettype wire

//--- design/text_row_layout.sv
`default_nettype none

module text_row_layout
   import scope_text_pkg::*;
#(
   parameter int TEXT_X0    = scope_text_pkg::TEXT_X0,
   parameter int ROW_Y_MAX  = scope_text_pkg::ROW_Y_MAX,
   parameter int ROW_Y_MIN  = scope_text_pkg::ROW_Y_MIN,
   parameter int ROW_Y_MEAN = scope_text_pkg::ROW_Y_MEAN,
   parameter int ROW_Y_TRIG = scope_text_pkg::ROW_Y_TRIG
) (
   input  wire         clk,
   input  wire         rst,
   input  wire coord_t hcount,
   input  wire coord_t vcount,
   input  wire bcd6_t  max_bcd,
   input  wire bcd6_t  min_bcd,
   input  wire bcd6_t  mean_bcd,
   input  wire bcd6_t  trig_bcd,
   output row_sel_t    row_sel,
   output glyph_code_t glyph_code,
   output logic [2:0]  glyph_line,
   output logic [2:0]  pixel_col
);

   localparam coord_t X_LO = coord_t'(TEXT_X0);
   localparam coord_t X_HI = coord_t'(TEXT_X0 + TEXT_CHARS * CHAR_W);

   coord_t      h_off;
   coord_t      v_off;
   coord_t      row_top;
   logic        in_span;
   logic [3:0]  band_hit;    // trig, mean, min, max
   logic [3:0]  char_idx;
   row_sel_t    row_nxt;
   bcd6_t       digits;
   glyph_code_t code_nxt;

   function automatic logic in_band(input coord_t v, input int top);
      return (v >= coord_t'(top)) && (v < coord_t'(top + ROW_H));
   endfunction

   // ----------------------------------------
   // beam position decode
   // ----------------------------------------
   assign in_span  = (hcount >= X_LO) && (hcount < X_HI);
   assign band_hit = {in_band(vcount, ROW_Y_TRIG), in_band(vcount, ROW_Y_MEAN),
                      in_band(vcount, ROW_Y_MIN), in_band(vcount, ROW_Y_MAX)};
   assign h_off    = hcount - X_LO;
   assign char_idx = 4'(h_off / CHAR_W);
   assign v_off    = vcount - row_top;

   always_comb begin
      row_nxt = ROW_NONE;
      row_top = coord_t'(ROW_Y_MAX);
      digits  = max_bcd;
      if (in_span && band_hit[0]) begin
         row_nxt = ROW_MAX;
      end else if (in_span && band_hit[1]) begin
         row_nxt = ROW_MIN;
         row_top = coord_t'(ROW_Y_MIN);
         digits  = min_bcd;
      end else if (in_span && band_hit[2]) begin
         row_nxt = ROW_MEAN;
         row_top = coord_t'(ROW_Y_MEAN);
         digits  = mean_bcd;
      end else if (in_span && band_hit[3]) begin
         row_nxt = ROW_TRIG;
         row_top = coord_t'(ROW_Y_TRIG);
         digits  = trig_bcd;
      end
   end

   // ----------------------------------------
   // character per column
   // ----------------------------------------
   always_comb begin
      code_nxt = GLYPH_SPACE;   // chars 11, 14 and the unused index
      case (char_idx)
         4'd0: code_nxt = (row_nxt == ROW_TRIG) ? GLYPH_UC_T : GLYPH_UC_V;
         4'd1: code_nxt = (row_nxt == ROW_TRIG) ? GLYPH_L : GLYPH_M;
         4'd2: begin
            case (row_nxt)
               ROW_MAX:  code_nxt = GLYPH_A;
               ROW_MIN:  code_nxt = GLYPH_I;
               ROW_MEAN: code_nxt = GLYPH_E;
               default:  code_nxt = GLYPH_LC_V;
            endcase
         end
         4'd3: begin
            case (row_nxt)
               ROW_MAX:  code_nxt = GLYPH_X;
               ROW_MIN:  code_nxt = GLYPH_N;
               ROW_MEAN: code_nxt = GLYPH_A;
               default:  code_nxt = GLYPH_L;
            endcase
         end
         4'd4:  code_nxt = GLYPH_EQ;
         4'd5:  code_nxt = glyph_code_t'(digits[23:20]);   // msd
         4'd6:  code_nxt = glyph_code_t'(digits[19:16]);
         4'd7:  code_nxt = glyph_code_t'(digits[15:12]);
         4'd8:  code_nxt = glyph_code_t'(digits[11:8]);
         4'd9:  code_nxt = glyph_code_t'(digits[7:4]);
         4'd10: code_nxt = glyph_code_t'(digits[3:0]);
         4'd12: code_nxt = GLYPH_M;
         4'd13: code_nxt = GLYPH_UC_V;
         default: code_nxt = GLYPH_SPACE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         row_sel <= ROW_NONE;
      end else begin
         row_sel <= row_nxt;
      end
   end

   always_ff @(posedge clk) begin
      glyph_code <= code_nxt;
      glyph_line <= v_off[3:1];              // each glyph line drawn twice
      pixel_col  <= 3'(h_off % CHAR_W);
   end

   // the row bands must not overlap on screen
   a_one_band : assert property (@(posedge clk) disable iff (rst) $onehot0(band_hit))
      else $error("overlapping text rows at vcount %0d", vcount);

endmodule

`default_nettype wire

//--- design/glyph_rom.sv
`default_nettype none

module glyph_rom
   import scope_text_pkg::*;
(
   input  wire              clk,
   input  wire glyph_code_t glyph_code,
   output glyph_bits_t      glyph
);

   localparam int DEPTH = 2 ** $bits(glyph_code_t);

   glyph_bits_t rom [DEPTH];

   // ----------------------------------------
   // font contents
   // ----------------------------------------
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         rom[i] = '0;   // unlisted codes stay blank
      end
      $readmemh("design/font_glyphs.mem", rom);
   end

   always_ff @(posedge clk) begin
      glyph <= rom[glyph_code];
   end

endmodule

`default_nettype wire

//--- design/overlay_mixer.sv
`default_nettype none

module overlay_mixer
   import scope_text_pkg::*;
(
   input  wire              clk,
   input  wire              rst,
   input  wire coord_t      hcount_in,
   input  wire coord_t      vcount_in,
   input  wire              hsync_in,
   input  wire              vsync_in,
   input  wire              hblnk_in,
   input  wire              vblnk_in,
   input  wire rgb_t        rgb_in,
   input  wire row_sel_t    row_sel,
   input  wire [2:0]        glyph_line,
   input  wire [2:0]        pixel_col,
   input  wire glyph_bits_t glyph,
   output coord_t           hcount_out,
   output coord_t           vcount_out,
   output logic             hsync_out,
   output logic             vsync_out,
   output logic             hblnk_out,
   output logic             vblnk_out,
   output rgb_t             rgb_out
);

   // 2-deep video delay, lines up with the rom output
   coord_t     hcount_d [2];
   coord_t     vcount_d [2];
   logic [1:0] hsync_d;
   logic [1:0] vsync_d;
   logic [1:0] hblnk_d;
   logic [1:0] vblnk_d;
   rgb_t       rgb_d [2];

   row_sel_t   row_d;
   logic [2:0] line_d;
   logic [2:0] col_d;
   logic       text_px;

   always_ff @(posedge clk) begin
      if (rst) begin
         hcount_d <= '{default: '0};
         vcount_d <= '{default: '0};
         hsync_d  <= '0;
         vsync_d  <= '0;
         hblnk_d  <= '0;
         vblnk_d  <= '0;
         rgb_d    <= '{default: '0};
         row_d    <= ROW_NONE;
      end else begin
         hcount_d <= '{hcount_in, hcount_d[0]};
         vcount_d <= '{vcount_in, vcount_d[0]};
         hsync_d  <= {hsync_d[0], hsync_in};
         vsync_d  <= {vsync_d[0], vsync_in};
         hblnk_d  <= {hblnk_d[0], hblnk_in};
         vblnk_d  <= {vblnk_d[0], vblnk_in};
         rgb_d    <= '{rgb_in, rgb_d[0]};
         row_d    <= row_sel;
      end
   end

   always_ff @(posedge clk) begin
      line_d <= glyph_line;
      col_d  <= pixel_col;
   end

   // bit 63 is line 0 pixel 0, so both indices count down
   assign text_px = glyph[{~line_d, ~col_d}];

   // ----------------------------------------
   // output register
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         hcount_out <= '0;
         vcount_out <= '0;
         hsync_out  <= 1'b0;
         vsync_out  <= 1'b0;
         hblnk_out  <= 1'b0;
         vblnk_out  <= 1'b0;
         rgb_out    <= '0;
      end else begin
         hcount_out <= hcount_d[1];
         vcount_out <= vcount_d[1];
         hsync_out  <= hsync_d[1];
         vsync_out  <= vsync_d[1];
         hblnk_out  <= hblnk_d[1];
         vblnk_out  <= vblnk_d[1];
         if (row_d != ROW_NONE) begin
            rgb_out <= text_px ? TEXT_FG : rgb_t'(0);   // black behind the text
         end else begin
            rgb_out <= rgb_d[1];                        // pass-through
         end
      end
   end

endmodule

`default_nettype wire

//--- design/meas_overlay.sv
`default_nettype none

module meas_overlay
   import scope_text_pkg::*;
(
   input  wire           clk,
   input  wire           rst,
   input  wire reading_t max_level,
   input  wire reading_t min_level,
   input  wire reading_t mean_level,
   input  wire reading_t trig_level,
   input  wire coord_t   hcount_in,
   input  wire coord_t   vcount_in,
   input  wire           hsync_in,
   input  wire           vsync_in,
   input  wire           hblnk_in,
   input  wire           vblnk_in,
   input  wire rgb_t     rgb_in,
   output coord_t        hcount_out,
   output coord_t        vcount_out,
   output logic          hsync_out,
   output logic          vsync_out,
   output logic          hblnk_out,
   output logic          vblnk_out,
   output rgb_t          rgb_out
);

   bcd6_t       max_bcd;
   bcd6_t       min_bcd;
   bcd6_t       mean_bcd;
   bcd6_t       trig_bcd;
   row_sel_t    row_sel;
   glyph_code_t glyph_code;
   logic [2:0]  glyph_line;
   logic [2:0]  pixel_col;
   glyph_bits_t glyph;

   // ----------------------------------------
   // reading conversion
   // ----------------------------------------
   reading_to_bcd #(.MV_PER_LSB(MV_PER_LSB)) u_max (
      .clk(clk), .rst(rst), .reading(max_level), .bcd(max_bcd)
   );
   reading_to_bcd #(.MV_PER_LSB(MV_PER_LSB)) u_min (
      .clk(clk), .rst(rst), .reading(min_level), .bcd(min_bcd)
   );
   reading_to_bcd #(.MV_PER_LSB(MV_PER_LSB)) u_mean (
      .clk(clk), .rst(rst), .reading(mean_level), .bcd(mean_bcd)
   );
   reading_to_bcd #(.MV_PER_LSB(MV_PER_LSB)) u_trig (
      .clk(clk), .rst(rst), .reading(trig_level), .bcd(trig_bcd)
   );

   // ----------------------------------------
   // text layout and font
   // ----------------------------------------
   text_row_layout #(
      .TEXT_X0   (TEXT_X0),
      .ROW_Y_MAX (ROW_Y_MAX),
      .ROW_Y_MIN (ROW_Y_MIN),
      .ROW_Y_MEAN(ROW_Y_MEAN),
      .ROW_Y_TRIG(ROW_Y_TRIG)
   ) u_layout (
      .clk       (clk),
      .rst       (rst),
      .hcount    (hcount_in),
      .vcount    (vcount_in),
      .max_bcd   (max_bcd),
      .min_bcd   (min_bcd),
      .mean_bcd  (mean_bcd),
      .trig_bcd  (trig_bcd),
      .row_sel   (row_sel),
      .glyph_code(glyph_code),
      .glyph_line(glyph_line),
      .pixel_col (pixel_col)
   );

   glyph_rom u_rom (
      .clk       (clk),
      .glyph_code(glyph_code),
      .glyph     (glyph)
   );

   overlay_mixer u_mixer (
      .clk       (clk),
      .rst       (rst),
      .hcount_in (hcount_in),
      .vcount_in (vcount_in),
      .hsync_in  (hsync_in),
      .vsync_in  (vsync_in),
      .hblnk_in  (hblnk_in),
      .vblnk_in  (vblnk_in),
      .rgb_in    (rgb_in),
      .row_sel   (row_sel),
      .glyph_line(glyph_line),
      .pixel_col (pixel_col),
      .glyph     (glyph),
      .hcount_out(hcount_out),
      .vcount_out(vcount_out),
      .hsync_out (hsync_out),
      .vsync_out (vsync_out),
      .hblnk_out (hblnk_out),
      .vblnk_out (vblnk_out),
      .rgb_out   (rgb_out)
   );

endmodule

`default_nettype wire

//--- testbench/meas_overlay_tb.sv
`default_nettype none

module meas_overlay_tb
   import scope_text_pkg::*;
();

   localparam int CLK_PERIOD = 40;
   localparam int NUM_CYCLES = 6000;
   localparam int SETTLE     = 6;     // cycles a reading needs to reach the pixels

   logic     clk;
   logic     rst;
   reading_t max_level, min_level, mean_level, trig_level;
   coord_t   hcount_in, vcount_in;
   logic     hsync_in, vsync_in, hblnk_in, vblnk_in;
   rgb_t     rgb_in;
   coord_t   hcount_out, vcount_out;
   logic     hsync_out, vsync_out, hblnk_out, vblnk_out;
   rgb_t     rgb_out;

   integer      seed;
   int          errors;
   int          timing_checks;
   int          text_checks;
   int          digit_checks;
   int          quiet;            // cycles since the last reading change
   glyph_bits_t font [32];

   // input history, index 0 is the newest sample
   coord_t     hist_h [3];
   coord_t     hist_v [3];
   logic [3:0] hist_ctl [3];     // hsync, vsync, hblnk, vblnk
   rgb_t       hist_rgb [3];
   logic       hist_rst [3];

   meas_overlay i_dut (
      .clk(clk), .rst(rst),
      .max_level(max_level), .min_level(min_level),
      .mean_level(mean_level), .trig_level(trig_level),
      .hcount_in(hcount_in), .vcount_in(vcount_in),
      .hsync_in(hsync_in), .vsync_in(vsync_in),
      .hblnk_in(hblnk_in), .vblnk_in(vblnk_in), .rgb_in(rgb_in),
      .hcount_out(hcount_out), .vcount_out(vcount_out),
      .hsync_out(hsync_out), .vsync_out(vsync_out),
      .hblnk_out(hblnk_out), .vblnk_out(vblnk_out), .rgb_out(rgb_out)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ----------------------------------------
   // reference model
   // ----------------------------------------
   function automatic int row_top(input int row);
      case (row)
         0:       return ROW_Y_MAX;
         1:       return ROW_Y_MIN;
         2:       return ROW_Y_MEAN;
         default: return ROW_Y_TRIG;
      endcase
   endfunction

   function automatic int row_of(input coord_t h, input coord_t v);
      if (h < TEXT_X0 || h >= TEXT_X0 + TEXT_CHARS * CHAR_W) begin
         return -1;
      end
      for (int r = 0; r < 4; r++) begin
         if (v >= row_top(r) && v < row_top(r) + ROW_H) begin
            return r;
         end
      end
      return -1;
   endfunction

   function automatic reading_t level_of(input int row);
      case (row)
         0:       return max_level;
         1:       return min_level;
         2:       return mean_level;
         default: return trig_level;
      endcase
   endfunction

   function automatic int glyph_index(input byte c);
      string set;
      set = "0123456789 =VmaxineTlv";
      for (int i = 0; i < set.len(); i++) begin
         if (set[i] == c) begin
            return i;
         end
      end
      return 31;   // blank entry
   endfunction

   // character at position ch of a row, then the pixel of its doubled glyph
   function automatic logic text_pixel(input int row, input coord_t h, input coord_t v,
                                       input reading_t level);
      string labels;
      int    hoff;
      int    voff;
      int    ch;
      int    mv;
      byte   c;
      glyph_bits_t g;
      labels = "Vmax=Vmin=Vmea=Tlvl=";
      hoff   = h - TEXT_X0;
      voff   = v - row_top(row);
      ch     = hoff / CHAR_W;
      mv     = level;
      mv     = mv * 3;
      if (ch < 5) begin
         c = labels[row * 5 + ch];
      end else if (ch <= 10) begin
         c = byte'(48 + (mv / (10 ** (10 - ch))) % 10);
      end else if (ch == 12) begin
         c = "m";
      end else if (ch == 13) begin
         c = "V";
      end else begin
         c = " ";
      end
      g = font[glyph_index(c)];
      return g[63 - 8 * (voff / 2) - hoff % CHAR_W];
   endfunction

   // ----------------------------------------
   // stimulus
   // ----------------------------------------
   task automatic pick_reading(output reading_t val);
      logic [31:0] r;
      r = $random(seed);
      if (r % 8 == 0) val = 12'd0;
      else if (r % 8 == 1) val = 12'd4095;
      else val = reading_t'(r >> 8);
   endtask

   task automatic change_levels();
      logic [31:0] r;
      reading_t    t;
      r = $random(seed);
      case (r % 4)
         0: begin
            t = max_level;     // swap max and min
            max_level = min_level;
            min_level = t;
         end
         1: begin
            t = mean_level;
            mean_level = trig_level;
            trig_level = t;
         end
         default: begin
            pick_reading(max_level);
            pick_reading(min_level);
            pick_reading(mean_level);
            pick_reading(trig_level);
         end
      endcase
      quiet = 0;
   endtask

   // beam mostly inside the text rows, else anywhere
   task automatic drive_video();
      logic [31:0] r1, r2, r3;
      r1 = $random(seed);
      r2 = $random(seed);
      r3 = $random(seed);
      if (r1 % 4 != 0) begin
         hcount_in = coord_t'(TEXT_X0 + r2 % (TEXT_CHARS * CHAR_W));
         vcount_in = coord_t'(row_top(r3 % 4) + (r3 >> 4) % ROW_H);
      end else begin
         hcount_in = coord_t'(r2);
         vcount_in = coord_t'(r3);
      end
      {hsync_in, vsync_in, hblnk_in, vblnk_in} = r1[11:8];
      rgb_in = rgb_t'(r1 >> 16);
   endtask

   // ----------------------------------------
   // checks
   // ----------------------------------------
   task automatic check_outputs();
      logic        any_rst;
      logic [25:0] exp_timing;
      rgb_t        exp_rgb;
      logic        check_rgb;
      int          row;
      int          ch;
      any_rst   = hist_rst[0] | hist_rst[1] | hist_rst[2];
      check_rgb = 1'b1;
      if (any_rst) begin
         exp_timing = '0;    // registers still cleared
         exp_rgb    = '0;
      end else begin
         exp_timing = {hist_h[2], hist_v[2], hist_ctl[2]};
         row = row_of(hist_h[2], hist_v[2]);
         if (row < 0) begin
            exp_rgb = hist_rgb[2];
         end else if (quiet < SETTLE) begin
            check_rgb = 1'b0;
            exp_rgb   = '0;
         end else begin
            exp_rgb = text_pixel(row, hist_h[2], hist_v[2], level_of(row)) ? TEXT_FG : '0;
            ch = (hist_h[2] - TEXT_X0) / CHAR_W;
            text_checks++;
            if (ch >= 5 && ch <= 10) digit_checks++;
         end
      end
      timing_checks++;
      if ({hcount_out, vcount_out, hsync_out, vsync_out, hblnk_out, vblnk_out}
          !== exp_timing) begin
         $display("Error at %0t: timing out h=%0d v=%0d ctl=%b, expected h=%0d v=%0d ctl=%b",
                  $time, hcount_out, vcount_out, {hsync_out, vsync_out, hblnk_out, vblnk_out},
                  exp_timing[25:15], exp_timing[14:4], exp_timing[3:0]);
         errors++;
      end
      if (check_rgb && rgb_out !== exp_rgb) begin
         $display("Error at %0t: rgb_out %h at h=%0d v=%0d, expected %h",
                  $time, rgb_out, hist_h[2], hist_v[2], exp_rgb);
         errors++;
      end
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial begin
      logic [31:0] r;
      seed = 9;
      clk = 1'b0;
      rst = 1'b1;
      {max_level, min_level, mean_level, trig_level} = '0;
      {hcount_in, vcount_in, rgb_in} = '0;
      {hsync_in, vsync_in, hblnk_in, vblnk_in} = '0;
      errors = 0;
      timing_checks = 0;
      text_checks = 0;
      digit_checks = 0;
      quiet = 0;
      for (int i = 0; i < 32; i++) font[i] = '0;
      $readmemh("design/font_glyphs.mem", font);
      for (int i = 0; i < 3; i++) begin
         hist_h[i] = '0;
         hist_v[i] = '0;
         hist_ctl[i] = '0;
         hist_rgb[i] = '0;
         hist_rst[i] = 1'b1;
      end

      for (int n = 1; n <= NUM_CYCLES; n++) begin
         @(posedge clk);
         for (int i = 2; i > 0; i--) begin
            hist_h[i]   = hist_h[i-1];
            hist_v[i]   = hist_v[i-1];
            hist_ctl[i] = hist_ctl[i-1];
            hist_rgb[i] = hist_rgb[i-1];
            hist_rst[i] = hist_rst[i-1];
         end
         hist_h[0]   = hcount_in;
         hist_v[0]   = vcount_in;
         hist_ctl[0] = {hsync_in, vsync_in, hblnk_in, vblnk_in};
         hist_rgb[0] = rgb_in;
         hist_rst[0] = rst;
         if (rst) quiet = 0;
         else if (quiet < 1000) quiet++;

         #2;
         rst = (n < 3);
         r = $random(seed);
         if (n == 3) begin
            max_level  = 12'd4095;   // extremes right after reset
            min_level  = 12'd0;
            pick_reading(mean_level);
            pick_reading(trig_level);
            quiet = 0;
         end else if (n > 3 && r % 40 == 0) begin
            change_levels();
         end
         drive_video();

         @(negedge clk);
         check_outputs();
      end

      if (digit_checks == 0) begin
         $display("No digit pixel was checked during the run");
         errors++;
      end
      $display("errors: %0d, timing checks: %0d, text pixel checks: %0d, digit pixels: %0d",
               errors, timing_checks, text_checks, digit_checks);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

   // watchdog
   initial begin
      #((NUM_CYCLES + 100) * CLK_PERIOD);
      $display("Timeout: the test did not finish in time");
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- design/font_glyphs.mem
// one 64-bit glyph per line, codes 0..21 in order: 0-9, space, =, V, m, a, x, i, n, e, T, l, v
// top byte is glyph line 0, msb is the leftmost pixel
3C666E7666663C00
1838181818187E00
3C66060C30607E00
3C66061C06663C00
0C1C3C6C7E0C0C00
7E607C0606663C00
3C607C6666663C00
7E060C1830303000
3C66663C66663C00
3C66663E060C3800
0000000000000000
00007E007E000000
66666666663C1800
0000667F7F6B6300
00003C063E663E00
0000663C183C6600
1800381818183C00
00007C6666666600
00003C667E603C00
7E18181818181800
3818181818183C00
00006666663C1800

//--- meas_overlay.f
design/scope_text_pkg.sv
design/reading_to_bcd.sv
design/text_row_layout.sv
design/glyph_rom.sv
design/overlay_mixer.sv
design/meas_overlay.sv
testbench/meas_overlay_tb.sv

//--- Bender.yml
package:
  name: meas_overlay

sources:
  - design/scope_text_pkg.sv
  - design/reading_to_bcd.sv
  - design/text_row_layout.sv
  - design/glyph_rom.sv
  - design/overlay_mixer.sv
  - design/meas_overlay.sv
  - target: test
    files:
      - testbench/meas_overlay_tb.sv
